// File: host_macros.svh
// Key codes, download indexes, status field positions and glue sizes
`ifndef HOST_MACROS_SVH
`define HOST_MACROS_SVH

// PS/2 set 2 scan codes of the cabinet keys
`define KEY_START1      8'h16
`define KEY_START2      8'h1E
`define KEY_COIN1       8'h2E
`define KEY_COIN2       8'h36
`define KEY_PAUSE       8'h4D
`define KEY_UP          8'h75
`define KEY_DOWN        8'h72
`define KEY_LEFT        8'h6B
`define KEY_RIGHT       8'h74
`define KEY_A           8'h14
`define KEY_B           8'h11
`define KEY_X           8'h29
`define KEY_Y           8'h12

// Download port indexes
`define IOCTL_INDEX_ROM 8'd0
`define IOCTL_INDEX_DIP 8'd254

// Storage and bus sizes
`define DIP_BYTES       8
`define DIP_USED        3
`define SDR_ADDR_W      25
`define STATUS_W        32
`define CROP_LINES      240

// Menu status word layout with two-bit fields given by their low bit
`define FLD_AR_LO       1
`define FLD_FX_LO       3
`define FLD_SCALE_LO    5
`define FLD_VT_LO       8
`define FLD_ROT         10
`define FLD_CROP        11
`define FLD_COFF_LO     12

`endif

// File: host_pkg.sv
// Shared types for SDRAM words, joystick words, DIP bytes and aspect values

`include "host_macros.svh"

package host_pkg;

    ////////////////////////////////
    // SDRAM channel
    ////////////////////////////////

    // Byte address into the SDRAM
    typedef logic [`SDR_ADDR_W-1:0] sdr_addr_t;

    typedef logic [15:0] sdr_word_t;

    // One enable per byte lane of a word
    typedef logic [1:0]  sdr_be_t;

    ////////////////////////////////
    // Host side
    ////////////////////////////////

    typedef logic [15:0] joy_word_t;

    typedef logic [7:0]  dip_byte_t;

    // Aspect ratio term or crop height in lines
    typedef logic [11:0] aspect_t;

endpackage

// File: ps2_button_decoder.sv
// PS/2 keyboard event decoder producing held cabinet button levels
`timescale 1ns/1ps

`include "host_macros.svh"

module ps2_button_decoder (
    input  logic        CLK_32M,
    input  logic        arst_n,
    input  logic [10:0] ps2_key,
    output logic        btn_up,
    output logic        btn_down,
    output logic        btn_left,
    output logic        btn_right,
    output logic        btn_a,
    output logic        btn_b,
    output logic        btn_x,
    output logic        btn_y,
    output logic        btn_coin1,
    output logic        btn_coin2,
    output logic        btn_start1,
    output logic        btn_start2,
    output logic        btn_pause
);

    logic       toggle_q;
    logic       key_event;
    logic       pressed;
    logic [7:0] code;

    assign pressed   = ps2_key[9];
    assign code      = ps2_key[7:0];
    // A flip of the toggle bit marks a new key event
    assign key_event = ps2_key[10] != toggle_q;

    always_ff @(posedge CLK_32M or negedge arst_n) begin
        if (!arst_n) begin
            toggle_q   <= 1'b0;
            btn_up     <= 1'b0;
            btn_down   <= 1'b0;
            btn_left   <= 1'b0;
            btn_right  <= 1'b0;
            btn_a      <= 1'b0;
            btn_b      <= 1'b0;
            btn_x      <= 1'b0;
            btn_y      <= 1'b0;
            btn_coin1  <= 1'b0;
            btn_coin2  <= 1'b0;
            btn_start1 <= 1'b0;
            btn_start2 <= 1'b0;
            btn_pause  <= 1'b0;
        end else begin
            toggle_q <= ps2_key[10];
            if (key_event) begin
                // Only the key of this event moves, unknown codes fall through
                case (code)
                    `KEY_START1: btn_start1 <= pressed;
                    `KEY_START2: btn_start2 <= pressed;
                    `KEY_COIN1:  btn_coin1  <= pressed;
                    `KEY_COIN2:  btn_coin2  <= pressed;
                    `KEY_PAUSE:  btn_pause  <= pressed;
                    `KEY_UP:     btn_up     <= pressed;
                    `KEY_DOWN:   btn_down   <= pressed;
                    `KEY_LEFT:   btn_left   <= pressed;
                    `KEY_RIGHT:  btn_right  <= pressed;
                    `KEY_A:      btn_a      <= pressed;   // ctrl
                    `KEY_B:      btn_b      <= pressed;   // alt
                    `KEY_X:      btn_x      <= pressed;   // space
                    `KEY_Y:      btn_y      <= pressed;   // shift
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: cabinet_input_mapper.sv
// Keyboard and joystick merge into the active-low cabinet inputs
`timescale 1ns/1ps

module cabinet_input_mapper (
    input  logic              btn_up,
    input  logic              btn_down,
    input  logic              btn_left,
    input  logic              btn_right,
    input  logic              btn_a,
    input  logic              btn_b,
    input  logic              btn_x,
    input  logic              btn_y,
    input  logic              btn_coin1,
    input  logic              btn_coin2,
    input  logic              btn_start1,
    input  logic              btn_start2,
    input  logic              btn_pause,
    input  host_pkg::joy_word_t joystick_0,
    input  host_pkg::joy_word_t joystick_1,
    output logic [1:0]        coin,
    output logic [1:0]        start_buttons,
    output logic [3:0]        p1_joystick,
    output logic [3:0]        p2_joystick,
    output logic [3:0]        p1_buttons,
    output logic [3:0]        p2_buttons,
    output logic              pause_button
);

    import host_pkg::*;

    joy_word_t  joy_any;
    logic [3:0] kbd_dir;
    logic [3:0] kbd_btn;

    // Start, coin and pause may come from either stick
    assign joy_any = joystick_0 | joystick_1;

    // Keys are shared by both players in up down left right order
    assign kbd_dir = {btn_up, btn_down, btn_left, btn_right};
    assign kbd_btn = {btn_a, btn_b, btn_x, btn_y};

    ////////////////////////////////
    // Player controls
    ////////////////////////////////

    // Stick bits 3:0 already sit in up down left right order
    assign p1_joystick = ~(kbd_dir | joystick_0[3:0]);
    assign p2_joystick = ~(kbd_dir | joystick_1[3:0]);

    // Button a is stick bit 4 and goes to the top
    assign p1_buttons = ~(kbd_btn | {joystick_0[4], joystick_0[5], joystick_0[6], joystick_0[7]});
    assign p2_buttons = ~(kbd_btn | {joystick_1[4], joystick_1[5], joystick_1[6], joystick_1[7]});

    ////////////////////////////////
    // Start, coin and pause
    ////////////////////////////////

    assign start_buttons = ~{btn_start2 | joy_any[10], btn_start1 | joy_any[8]};
    assign coin          = ~{btn_coin2, btn_coin1 | joy_any[9]};
    assign pause_button  = btn_pause | joy_any[11];

endmodule

// File: dip_switch_bank.sv
// DIP byte store written by the download port and the inverted switch word
`timescale 1ns/1ps

`include "host_macros.svh"

module dip_switch_bank (
    input  logic                  CLK_32M,
    input  logic                  arst_n,
    input  logic                  ioctl_wr,
    input  logic [7:0]            ioctl_index,
    input  host_pkg::sdr_addr_t   ioctl_addr,
    input  host_pkg::dip_byte_t   ioctl_dout,
    output logic [8*`DIP_USED-1:0] dip_sw
);

    import host_pkg::*;

    dip_byte_t dip_mem [`DIP_BYTES];
    logic      dip_we;

    // Only the first eight addresses of the DIP download are kept
    assign dip_we = ioctl_wr && (ioctl_index == `IOCTL_INDEX_DIP) &&
                    (ioctl_addr[`SDR_ADDR_W-1:3] == '0);

    always_ff @(posedge CLK_32M or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `DIP_BYTES; i++) begin
                dip_mem[i] <= '0;
            end
        end else if (dip_we) begin
            dip_mem[ioctl_addr[2:0]] <= ioctl_dout;
        end
    end

    // Board switches are active low, byte 0 lands in the low bits
    for (genvar g = 0; g < `DIP_USED; g++) begin : g_dip_out
        assign dip_sw[8*g +: 8] = ~dip_mem[g];
    end

endmodule

// File: sdram_ch3_mux.sv
// SDRAM channel 3 steering between ROM download and CPU access
`timescale 1ns/1ps

`include "host_macros.svh"

module sdram_ch3_mux (
    input  logic                ioctl_download,
    input  logic [7:0]          ioctl_index,
    input  host_pkg::sdr_addr_t rom_addr,
    input  host_pkg::sdr_word_t rom_data,
    input  host_pkg::sdr_be_t   rom_be,
    input  logic                rom_req,
    input  host_pkg::sdr_addr_t cpu_addr,
    input  host_pkg::sdr_word_t cpu_din,
    input  host_pkg::sdr_be_t   cpu_wr_sel,
    input  logic                cpu_req,
    input  logic                ch3_rdy,
    output host_pkg::sdr_addr_t ch3_addr,
    output host_pkg::sdr_word_t ch3_din,
    output host_pkg::sdr_be_t   ch3_be,
    output logic                ch3_rnw,
    output logic                ch3_req,
    output logic                rom_rdy,
    output logic                cpu_rdy
);

    logic rom_write;

    // ROM image download owns the channel while it runs
    assign rom_write = ioctl_download && (ioctl_index == `IOCTL_INDEX_ROM);

    assign ch3_addr = rom_write ? rom_addr : cpu_addr;
    assign ch3_din  = rom_write ? rom_data : cpu_din;
    assign ch3_be   = rom_write ? rom_be   : cpu_wr_sel;
    assign ch3_req  = rom_write ? rom_req  : cpu_req;

    // Loader only writes, CPU reads when no byte lane is selected
    assign ch3_rnw  = rom_write ? 1'b0 : ~(|cpu_wr_sel);

    // Requesters hold req until ready, so one ready line serves both
    assign rom_rdy = ch3_rdy;
    assign cpu_rdy = ch3_rdy;

endmodule

// File: video_option_decoder.sv
// Menu status decode into aspect, crop, scanline and video mode change options
`timescale 1ns/1ps

`include "host_macros.svh"

module video_option_decoder (
    input  logic                 CLK_32M,
    input  logic                 arst_n,
    input  logic [`STATUS_W-1:0] status,
    input  logic                 forced_scandoubler,
    output logic                 new_vmode,
    output host_pkg::aspect_t    arx,
    output host_pkg::aspect_t    ary,
    output host_pkg::aspect_t    crop_size,
    output logic [4:0]           crop_offset,
    output logic [1:0]           scale,
    output logic [1:0]           vga_sl,
    output logic                 scandoubler_en
);

    import host_pkg::*;

    logic [1:0] ar;
    logic [1:0] fx;
    logic [1:0] vtiming;
    logic [1:0] vtiming_q;
    logic       vertical;
    logic       crop_240p;
    logic [4:0] coff;

    assign ar       = status[`FLD_AR_LO +: 2];
    assign fx       = status[`FLD_FX_LO +: 2];
    assign scale    = status[`FLD_SCALE_LO +: 2];
    assign vtiming  = status[`FLD_VT_LO +: 2];
    assign vertical = status[`FLD_ROT];
    assign coff     = status[`FLD_COFF_LO +: 5];

    ////////////////////////////////
    // Aspect ratio and crop
    ////////////////////////////////

    // Original ratio swaps to 3:4 on a rotated screen
    assign arx = (ar == 2'd0) ? (vertical ? aspect_t'(3) : aspect_t'(4))
                              : aspect_t'(ar - 2'd1);
    assign ary = (ar == 2'd0) ? (vertical ? aspect_t'(4) : aspect_t'(3))
                              : aspect_t'(0);

    // 240p crop only makes sense on the native scaler path
    assign crop_240p = !forced_scandoubler && (scale == 2'd0) && status[`FLD_CROP];
    assign crop_size = crop_240p ? aspect_t'(`CROP_LINES) : aspect_t'(0);

    // Menu values 9..16 stand for offsets -8..-1
    assign crop_offset = (coff < 5'd9) ? coff : coff + 5'd15;

    ////////////////////////////////
    // Scanlines and mode change
    ////////////////////////////////

    assign vga_sl         = fx;
    assign scandoubler_en = forced_scandoubler || (fx != 2'd0);

    // Scaler re-reads the mode whenever this toggle flips
    always_ff @(posedge CLK_32M or negedge arst_n) begin
        if (!arst_n) begin
            vtiming_q <= 2'd0;
            new_vmode <= 1'b0;
        end else if (vtiming != vtiming_q) begin
            vtiming_q <= vtiming;
            new_vmode <= ~new_vmode;
        end
    end

endmodule

// File: host_glue_top.sv
// Top level of the host glue with keyboard, cabinet, DIP, SDRAM mux and video blocks
`timescale 1ns/1ps

`include "host_macros.svh"

module host_glue_top (
    input  logic                   CLK_32M,
    input  logic                   arst_n,
    // Keyboard and sticks
    input  logic [10:0]            ps2_key,
    input  host_pkg::joy_word_t    joystick_0,
    input  host_pkg::joy_word_t    joystick_1,
    // Download port
    input  logic                   ioctl_download,
    input  logic                   ioctl_wr,
    input  logic [7:0]             ioctl_index,
    input  host_pkg::sdr_addr_t    ioctl_addr,
    input  host_pkg::dip_byte_t    ioctl_dout,
    // SDRAM requesters
    input  host_pkg::sdr_addr_t    rom_addr,
    input  host_pkg::sdr_word_t    rom_data,
    input  host_pkg::sdr_be_t      rom_be,
    input  logic                   rom_req,
    input  host_pkg::sdr_addr_t    cpu_addr,
    input  host_pkg::sdr_word_t    cpu_din,
    input  host_pkg::sdr_be_t      cpu_wr_sel,
    input  logic                   cpu_req,
    input  logic                   ch3_rdy,
    // Menu
    input  logic [`STATUS_W-1:0]   status,
    input  logic                   forced_scandoubler,
    // Cabinet side, active low
    output logic [1:0]             coin,
    output logic [1:0]             start_buttons,
    output logic [3:0]             p1_joystick,
    output logic [3:0]             p2_joystick,
    output logic [3:0]             p1_buttons,
    output logic [3:0]             p2_buttons,
    output logic                   pause_button,
    output logic [8*`DIP_USED-1:0] dip_sw,
    // SDRAM channel 3
    output host_pkg::sdr_addr_t    ch3_addr,
    output host_pkg::sdr_word_t    ch3_din,
    output host_pkg::sdr_be_t      ch3_be,
    output logic                   ch3_rnw,
    output logic                   ch3_req,
    output logic                   rom_rdy,
    output logic                   cpu_rdy,
    // Video options
    output logic                   new_vmode,
    output host_pkg::aspect_t      arx,
    output host_pkg::aspect_t      ary,
    output host_pkg::aspect_t      crop_size,
    output logic [4:0]             crop_offset,
    output logic [1:0]             scale,
    output logic [1:0]             vga_sl,
    output logic                   scandoubler_en
);

    logic btn_up, btn_down, btn_left, btn_right;
    logic btn_a, btn_b, btn_x, btn_y;
    logic btn_coin1, btn_coin2, btn_start1, btn_start2, btn_pause;

    ////////////////////////////////
    // Keyboard and cabinet inputs
    ////////////////////////////////

    ps2_button_decoder u_ps2 (
        .CLK_32M, .arst_n, .ps2_key,
        .btn_up, .btn_down, .btn_left, .btn_right,
        .btn_a, .btn_b, .btn_x, .btn_y,
        .btn_coin1, .btn_coin2, .btn_start1, .btn_start2, .btn_pause
    );

    cabinet_input_mapper u_cabinet (
        .btn_up, .btn_down, .btn_left, .btn_right,
        .btn_a, .btn_b, .btn_x, .btn_y,
        .btn_coin1, .btn_coin2, .btn_start1, .btn_start2, .btn_pause,
        .joystick_0, .joystick_1,
        .coin, .start_buttons, .p1_joystick, .p2_joystick,
        .p1_buttons, .p2_buttons, .pause_button
    );

    ////////////////////////////////
    // Download port consumers
    ////////////////////////////////

    dip_switch_bank u_dip (
        .CLK_32M, .arst_n, .ioctl_wr, .ioctl_index, .ioctl_addr, .ioctl_dout,
        .dip_sw
    );

    sdram_ch3_mux u_ch3 (
        .ioctl_download, .ioctl_index,
        .rom_addr, .rom_data, .rom_be, .rom_req,
        .cpu_addr, .cpu_din, .cpu_wr_sel, .cpu_req, .ch3_rdy,
        .ch3_addr, .ch3_din, .ch3_be, .ch3_rnw, .ch3_req, .rom_rdy, .cpu_rdy
    );

    video_option_decoder u_video (
        .CLK_32M, .arst_n, .status, .forced_scandoubler,
        .new_vmode, .arx, .ary, .crop_size, .crop_offset,
        .scale, .vga_sl, .scandoubler_en
    );

endmodule

// File: tb_host_glue_checks.svh
// Output checks against the reference rules and the stimulus tasks of the host glue testbench

    // Immediate assertion on one output
    task automatic expect_hex(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR %s expected %0h got %0h at %0d ns", name, exp, act, $time);
            err_count++;
        end
    endtask

    task automatic next_edge();
        @(posedge CLK_32M);
        #1;
    endtask

    // A flip of the toggle bit announces the event
    task automatic send_key(input logic [7:0] code, input logic pressed);
        key_toggle = ~key_toggle;
        ps2_key    = {key_toggle, pressed, 1'b0, code};
    endtask

    task automatic key_and_check(input int idx, input logic pressed);
        send_key(key_codes[idx], pressed);
        next_edge();
        next_edge();
        kb_held[idx] = pressed;
        check_cabinet();
    endtask

    task automatic dip_write(input logic [7:0] index, input sdr_addr_t addr,
                             input dip_byte_t data);
        ioctl_wr    = 1'b1;
        ioctl_index = index;
        ioctl_addr  = addr;
        ioctl_dout  = data;
        next_edge();
        ioctl_wr = 1'b0;
    endtask

    ////////////////////////////////
    // Cabinet inputs
    ////////////////////////////////

    task automatic check_cabinet();
        joy_word_t  both;
        logic [3:0] kb_dir;
        logic [3:0] kb_btn;
        logic [3:0] p1_exp;
        logic [3:0] p2_exp;
        logic [1:0] pair_exp;
        both   = joystick_0 | joystick_1;
        kb_dir = {kb_held[0], kb_held[1], kb_held[2], kb_held[3]};
        kb_btn = {kb_held[4], kb_held[5], kb_held[6], kb_held[7]};
        // Stick bit 3 is up and bit 0 is right
        p1_exp = ~(kb_dir | joystick_0[3:0]);
        p2_exp = ~(kb_dir | joystick_1[3:0]);
        expect_hex("p1_joystick", 32'(p1_exp), 32'(p1_joystick));
        expect_hex("p2_joystick", 32'(p2_exp), 32'(p2_joystick));
        p1_exp = ~(kb_btn | {joystick_0[4], joystick_0[5], joystick_0[6], joystick_0[7]});
        p2_exp = ~(kb_btn | {joystick_1[4], joystick_1[5], joystick_1[6], joystick_1[7]});
        expect_hex("p1_buttons", 32'(p1_exp), 32'(p1_buttons));
        expect_hex("p2_buttons", 32'(p2_exp), 32'(p2_buttons));
        pair_exp = ~{kb_held[11] | both[10], kb_held[10] | both[8]};
        expect_hex("start_buttons", 32'(pair_exp), 32'(start_buttons));
        pair_exp = ~{kb_held[9], kb_held[8] | both[9]};
        expect_hex("coin", 32'(pair_exp), 32'(coin));
        expect_hex("pause_button", 32'(kb_held[12] | both[11]), 32'(pause_button));
    endtask

    ////////////////////////////////
    // DIP, SDRAM and video
    ////////////////////////////////

    task automatic check_dip();
        logic [23:0] dip_exp;
        dip_exp = ~{dip_model[2], dip_model[1], dip_model[0]};
        expect_hex("dip_sw", 32'(dip_exp), 32'(dip_sw));
    endtask

    task automatic check_mux();
        logic rom_sel;
        rom_sel = ioctl_download && ioctl_index == `IOCTL_INDEX_ROM;
        expect_hex("ch3_addr", 32'(rom_sel ? rom_addr : cpu_addr), 32'(ch3_addr));
        expect_hex("ch3_din", 32'(rom_sel ? rom_data : cpu_din), 32'(ch3_din));
        expect_hex("ch3_be", 32'(rom_sel ? rom_be : cpu_wr_sel), 32'(ch3_be));
        expect_hex("ch3_req", 32'(rom_sel ? rom_req : cpu_req), 32'(ch3_req));
        expect_hex("ch3_rnw", 32'(!rom_sel && cpu_wr_sel == 2'b00), 32'(ch3_rnw));
        expect_hex("rom_rdy", 32'(ch3_rdy), 32'(rom_rdy));
        expect_hex("cpu_rdy", 32'(ch3_rdy), 32'(cpu_rdy));
    endtask

    task automatic check_video();
        logic [1:0] ar;
        logic [1:0] fx;
        logic [4:0] coff;
        logic       crop_on;
        aspect_t    exp_x;
        aspect_t    exp_y;
        ar      = status[`FLD_AR_LO +: 2];
        fx      = status[`FLD_FX_LO +: 2];
        coff    = status[`FLD_COFF_LO +: 5];
        crop_on = !forced_scandoubler && status[`FLD_SCALE_LO +: 2] == 2'd0 && status[`FLD_CROP];
        exp_x   = (ar == 2'd0) ? (status[`FLD_ROT] ? 12'd3 : 12'd4) : aspect_t'(ar) - 12'd1;
        exp_y   = (ar == 2'd0) ? (status[`FLD_ROT] ? 12'd4 : 12'd3) : 12'd0;
        expect_hex("arx", 32'(exp_x), 32'(arx));
        expect_hex("ary", 32'(exp_y), 32'(ary));
        expect_hex("crop_size", crop_on ? `CROP_LINES : 0, 32'(crop_size));
        // Field values of 9 and above wrap to negative offsets
        expect_hex("crop_offset", (coff < 5'd9) ? 32'(coff) : (32'(coff) + 15) % 32,
                   32'(crop_offset));
        expect_hex("scale", 32'(status[`FLD_SCALE_LO +: 2]), 32'(scale));
        expect_hex("vga_sl", 32'(fx), 32'(vga_sl));
        expect_hex("scandoubler_en", 32'(forced_scandoubler || fx != 2'd0),
                   32'(scandoubler_en));
    endtask

// File: tb_host_glue.sv
// Testbench top with clock, reset, watchdog, LFSR and the test sequence
`timescale 1ns/1ps

`include "host_macros.svh"

module tb_host_glue;

    import host_pkg::*;

    // Cycles per test for reset, keys, sticks, DIP, SDRAM and video
    localparam int run_cycles   = 18 + 58 + 41 + 108 + 32 + 84;
    localparam int limit_cycles = run_cycles + 200;

    // Scan codes in the bit order of kb_held
    localparam logic [7:0] key_codes [13] = '{
        `KEY_UP, `KEY_DOWN, `KEY_LEFT, `KEY_RIGHT, `KEY_A, `KEY_B, `KEY_X, `KEY_Y,
        `KEY_COIN1, `KEY_COIN2, `KEY_START1, `KEY_START2, `KEY_PAUSE
    };

    logic        CLK_32M = 1'b0;
    logic        arst_n;
    logic [10:0] ps2_key;
    joy_word_t   joystick_0, joystick_1;
    logic        ioctl_download, ioctl_wr, rom_req, cpu_req, ch3_rdy, forced_scandoubler;
    logic [7:0]  ioctl_index;
    sdr_addr_t   ioctl_addr, rom_addr, cpu_addr, ch3_addr;
    dip_byte_t   ioctl_dout;
    sdr_word_t   rom_data, cpu_din, ch3_din;
    sdr_be_t     rom_be, cpu_wr_sel, ch3_be;
    logic [`STATUS_W-1:0] status;
    logic [1:0]  coin, start_buttons, scale, vga_sl;
    logic [3:0]  p1_joystick, p2_joystick, p1_buttons, p2_buttons;
    logic        pause_button, ch3_rnw, ch3_req, rom_rdy, cpu_rdy, new_vmode, scandoubler_en;
    logic [23:0] dip_sw;
    aspect_t     arx, ary, crop_size;
    logic [4:0]  crop_offset;

    // Reference state
    logic [12:0] kb_held;
    logic        key_toggle;
    dip_byte_t   dip_model [`DIP_BYTES];
    logic [1:0]  vt_copy;
    logic        vmode_exp;
    logic [15:0] lfsr_state;
    int          err_count, test_err_base, tests_passed, tests_failed;

    host_glue_top dut (.*);

    always #5 CLK_32M = ~CLK_32M;

    `include "tb_host_glue_checks.svh"

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic start_test();
        test_err_base = err_count;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = err_count - test_err_base;
        if (errs == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("[%0d ns] test %s done, %0d errors", $time, name, errs);
    endtask

    task automatic run_keyboard_test();
        start_test();
        for (int i = 0; i < 13; i++) begin
            key_and_check(i, 1'b1);
            key_and_check(i, 1'b0);
        end
        // Unknown code while start 1 is held
        key_and_check(10, 1'b1);
        send_key(8'h5A, 1'b1);
        next_edge();
        next_edge();
        check_cabinet();
        key_and_check(10, 1'b0);
        end_test("keyboard");
    endtask

    task automatic run_joystick_test();
        start_test();
        for (int n = 0; n < 41; n++) begin
            joystick_0 = (n % 3 == 1) ? '0 : joy_word_t'(rand_bits(16));
            joystick_1 = (n % 3 == 0) ? '0 : joy_word_t'(rand_bits(16));
            if (n == 40) begin
                joystick_0 = 16'hFFFF;
                joystick_1 = 16'hFFFF;
            end
            @(negedge CLK_32M);
            check_cabinet();
            next_edge();
        end
        joystick_0 = '0;
        joystick_1 = '0;
        end_test("joysticks");
    endtask

    task automatic run_dip_test();
        sdr_addr_t  addr;
        dip_byte_t  data;
        logic [7:0] index;
        start_test();
        for (int n = 0; n < 54; n++) begin
            addr  = sdr_addr_t'(rand_bits(3));
            data  = dip_byte_t'(rand_bits(8));
            index = `IOCTL_INDEX_DIP;
            // Ignored writes aim at a shown byte with data that would change it
            if (n >= 24) begin
                addr = sdr_addr_t'(n % 3);
                data = ~dip_model[n % 3];
            end
            if (n >= 24 && n < 46) begin
                // One upper address bit alone has to block the write
                addr[n - 21] = 1'b1;
            end else if (n >= 46) begin
                index = 8'(rand_bits(8));
                if (index == `IOCTL_INDEX_DIP) index = 8'd253;
            end
            dip_write(index, addr, data);
            if (n < 24) dip_model[addr[2:0]] = data;
            @(negedge CLK_32M);
            check_dip();
            next_edge();
        end
        end_test("dip_switches");
    endtask

    task automatic run_mux_test();
        start_test();
        for (int combo = 0; combo < 4; combo++) begin
            for (int n = 0; n < 8; n++) begin
                ioctl_download = combo[1];
                ioctl_index    = combo[0] ? (8'(rand_bits(8)) | 8'h01) : `IOCTL_INDEX_ROM;
                rom_addr       = sdr_addr_t'(rand_bits(25));
                rom_data       = sdr_word_t'(rand_bits(16));
                rom_be         = sdr_be_t'(rand_bits(2));
                rom_req        = 1'(rand_bits(1));
                cpu_addr       = sdr_addr_t'(rand_bits(25));
                cpu_din        = sdr_word_t'(rand_bits(16));
                cpu_wr_sel     = sdr_be_t'(n);
                cpu_req        = 1'(rand_bits(1));
                ch3_rdy        = 1'(rand_bits(1));
                @(negedge CLK_32M);
                check_mux();
                next_edge();
            end
        end
        ioctl_download = 1'b0;
        end_test("sdram_mux");
    endtask

    task automatic run_video_test();
        start_test();
        for (int n = 0; n < 84; n++) begin
            if (n < 80) begin
                status             = rand_bits(32);
                forced_scandoubler = 1'(rand_bits(1));
            end
            if (n >= 48 && n < 80) status[`FLD_COFF_LO +: 5] = 5'(n - 48);
            // Every third cycle keeps the timing field
            if (n % 3 == 2) status[`FLD_VT_LO +: 2] = vt_copy;
            @(negedge CLK_32M);
            check_video();
            expect_hex("new_vmode", 32'(vmode_exp), 32'(new_vmode));
            next_edge();
            if (status[`FLD_VT_LO +: 2] != vt_copy) begin
                vmode_exp = ~vmode_exp;
                vt_copy   = status[`FLD_VT_LO +: 2];
            end
            expect_hex("new_vmode", 32'(vmode_exp), 32'(new_vmode));
        end
        end_test("video_options");
    endtask

    initial begin
        arst_n             = 1'b0;
        ps2_key            = '0;
        joystick_0         = '0;
        joystick_1         = '0;
        ioctl_download     = 1'b0;
        ioctl_wr           = 1'b0;
        ioctl_index        = '0;
        ioctl_addr         = '0;
        ioctl_dout         = '0;
        rom_addr           = '0;
        rom_data           = '0;
        rom_be             = '0;
        rom_req            = 1'b0;
        cpu_addr           = '0;
        cpu_din            = '0;
        cpu_wr_sel         = '0;
        cpu_req            = 1'b0;
        ch3_rdy            = 1'b0;
        status             = '0;
        forced_scandoubler = 1'b0;
        kb_held            = '0;
        key_toggle         = 1'b0;
        vt_copy            = '0;
        vmode_exp          = 1'b0;
        lfsr_state         = 16'd44520;
        err_count          = 0;
        test_err_base      = 0;
        tests_passed       = 0;
        tests_failed       = 0;
        for (int i = 0; i < `DIP_BYTES; i++) dip_model[i] = '0;
        repeat (16) @(posedge CLK_32M);
        #1;
        arst_n = 1'b1;
        next_edge();
        // Reset state has all keys released and the DIP store clear
        start_test();
        @(negedge CLK_32M);
        check_cabinet();
        expect_hex("dip_sw", 32'hFFFFFF, 32'(dip_sw));
        expect_hex("new_vmode", 32'h0, 32'(new_vmode));
        end_test("reset_values");
        next_edge();
        run_keyboard_test();
        run_joystick_test();
        run_dip_test();
        run_mux_test();
        run_video_test();
        $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (limit_cycles) @(posedge CLK_32M);
        $display("Watchdog expired after %0d cycles, the test sequence did not finish",
                 limit_cycles);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
host_pkg.sv
ps2_button_decoder.sv
cabinet_input_mapper.sv
dip_switch_bank.sv
sdram_ch3_mux.sv
video_option_decoder.sv
host_glue_top.sv
tb_host_glue.sv

// File: Makefile
# Verilator build and run of the host glue testbench

VERILATOR ?= verilator
TOP       ?= tb_host_glue
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_TEXT ?= Test failures found
PASS_TEXT ?= All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "FAIL: run ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
